// File: Makefile
# Verilator build and run for the HMC bring-up supervisor

TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_hmc_bringup
FILELIST   := list.f
MDIR       := obj_dir
BIN        := $(MDIR)/V$(TOP)
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(MDIR)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(MDIR) $(LOG)

// File: design/hmc_bringup_macros.svh
// HMC bring-up supervisor constants
// Synchronizer depth, link count, counter widths and the
// bit positions that mark timeout, retry end and POST threshold
`ifndef HMC_BRINGUP_MACROS_SVH
`define HMC_BRINGUP_MACROS_SVH

// Flops per synchronizer chain
`define HMC_SYNC_DEPTH     4

// Link2 and link3 on the mezzanine
`define HMC_NUM_LINKS      2

`define HMC_FLIT_CNT_W     16

// Training watchdog, 1024 cycles to timeout
`define HMC_TIMEOUT_W      12
`define HMC_TIMEOUT_BIT    10

// Retry reset length, 16 cycles
`define HMC_RETRY_LEN_W    5
`define HMC_RETRY_BIT      4

// POST needs 256 flits on each link
`define HMC_POST_FLIT_BIT  8

`endif

// File: design/hmc_bringup_pkg.sv
// HMC bring-up supervisor types
// Counter vectors, per-link bit vector and the watchdog FSM states
`include "hmc_bringup_macros.svh"

package hmc_bringup_pkg;

  // Received-flit or error-flit count
  typedef logic [`HMC_FLIT_CNT_W-1:0] flit_cnt_t;

  // One bit per link, bit 0 link2, bit 1 link3
  typedef logic [`HMC_NUM_LINKS-1:0] link_vec_t;

  // Link training watchdog
  typedef logic [`HMC_TIMEOUT_W-1:0] timeout_cnt_t;

  // Length of the retry reset pulse
  typedef logic [`HMC_RETRY_LEN_W-1:0] retry_cnt_t;

  typedef enum logic [1:0] {
    WAIT_TRAIN,   // Links still training
    RETRY,        // Retry reset driven
    TRAINED       // Both links up
  } train_state_t;

endpackage

// File: design/hmc_bringup_top.sv
// Top level of the HMC bring-up supervisor
// Synchronizer stage, training watchdog and POST monitor in a chain,
// with the retry reset fed back into the soft reset terms
`timescale 1ns/1ps

module hmc_bringup_top (
  input  logic                       USER_CLK,
  input  logic                       hmc_resetRRRR,   // Mezzanine reset, already synchronous
  input  logic                       user_rst_i,      // Raw user reset
  input  hmc_bringup_pkg::link_vec_t qpll_lock_i,
  input  hmc_bringup_pkg::link_vec_t open_hmc_done_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_flit_cnt_link2_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_flit_cnt_link3_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_err_cnt_link2_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_err_cnt_link3_i,
  output hmc_bringup_pkg::link_vec_t soft_reset_link_o,
  output logic                       soft_reset_o,
  output logic                       retry_rst_o,
  output logic                       post_done_o,
  output logic                       post_ok_o
);
  import hmc_bringup_pkg::*;

  logic      user_rst_s;   // User reset in USER_CLK
  link_vec_t trained_s;    // Synchronized training done per link

  //----------------------------------------
  // Synchronizers and soft resets
  //----------------------------------------
  hmc_sync_stage u_sync (
    .USER_CLK          (USER_CLK),
    .hmc_resetRRRR     (hmc_resetRRRR),
    .user_rst_i        (user_rst_i),
    .qpll_lock_i       (qpll_lock_i),
    .open_hmc_done_i   (open_hmc_done_i),
    .retry_rst_i       (retry_rst_o),        // Watchdog feedback
    .user_rst_o        (user_rst_s),
    .trained_o         (trained_s),
    .soft_reset_link_o (soft_reset_link_o),
    .soft_reset_o      (soft_reset_o)
  );

  //----------------------------------------
  // Training watchdog
  //----------------------------------------
  hmc_train_watchdog u_watchdog (
    .USER_CLK      (USER_CLK),
    .hmc_resetRRRR (hmc_resetRRRR),
    .user_rst_i    (user_rst_s),
    .trained_i     (trained_s),
    .retry_rst_o   (retry_rst_o)
  );

  //----------------------------------------
  // POST verdict
  //----------------------------------------
  hmc_post_monitor u_post (
    .USER_CLK            (USER_CLK),
    .hmc_resetRRRR       (hmc_resetRRRR),
    .user_rst_i          (user_rst_s),
    .rx_flit_cnt_link2_i (rx_flit_cnt_link2_i),
    .rx_flit_cnt_link3_i (rx_flit_cnt_link3_i),
    .rx_err_cnt_link2_i  (rx_err_cnt_link2_i),
    .rx_err_cnt_link3_i  (rx_err_cnt_link3_i),
    .post_done_o         (post_done_o),
    .post_ok_o           (post_ok_o)
  );

endmodule

// File: design/hmc_post_monitor.sv
// POST verdict for the HMC bring-up supervisor
// POST done from the per-link received-flit counts, POST OK from
// done with clean error counts, synchronized and latched on its
// rising edge
`timescale 1ns/1ps
`include "hmc_bringup_macros.svh"

module hmc_post_monitor (
  input  logic                       USER_CLK,
  input  logic                       hmc_resetRRRR,
  input  logic                       user_rst_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_flit_cnt_link2_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_flit_cnt_link3_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_err_cnt_link2_i,
  input  hmc_bringup_pkg::flit_cnt_t rx_err_cnt_link3_i,
  output logic                       post_done_o,
  output logic                       post_ok_o
);
  import hmc_bringup_pkg::*;

  logic                       post_done_c;
  logic                       post_ok_c;
  logic [`HMC_SYNC_DEPTH-1:0] post_ok_q;
  logic                       post_ok_sync_d;   // Last chain stage, one cycle late
  logic                       post_ok_rise;

  //----------------------------------------
  // POST conditions
  //----------------------------------------
  // Enough flits seen on both links
  assign post_done_c = rx_flit_cnt_link2_i[`HMC_POST_FLIT_BIT] &
                       rx_flit_cnt_link3_i[`HMC_POST_FLIT_BIT];

  assign post_ok_c = post_done_c &&
                     (rx_err_cnt_link2_i == flit_cnt_t'(0)) &&
                     (rx_err_cnt_link3_i == flit_cnt_t'(0));

  always_ff @(posedge USER_CLK) begin
    if (hmc_resetRRRR) begin
      post_done_o <= 1'b0;
    end else begin
      post_done_o <= post_done_c;
    end
  end

  //----------------------------------------
  // POST OK sync and latch
  //----------------------------------------
  assign post_ok_rise = post_ok_q[`HMC_SYNC_DEPTH-1] & ~post_ok_sync_d;

  always_ff @(posedge USER_CLK) begin
    if (hmc_resetRRRR || user_rst_i) begin
      post_ok_q      <= '0;
      post_ok_sync_d <= 1'b0;
      post_ok_o      <= 1'b0;
    end else begin
      post_ok_q      <= {post_ok_q[`HMC_SYNC_DEPTH-2:0], post_ok_c};
      post_ok_sync_d <= post_ok_q[`HMC_SYNC_DEPTH-1];
      // Sticky once set, later errors do not clear it
      if (post_ok_rise) begin
        post_ok_o <= 1'b1;
      end
    end
  end

endmodule

// File: design/hmc_sync_stage.sv
// Reset synchronization for the HMC bring-up supervisor
// Builds the per-link and combined soft reset terms and passes them,
// the user reset and the link-training done levels through
// four-flop chains into USER_CLK
`timescale 1ns/1ps
`include "hmc_bringup_macros.svh"

module hmc_sync_stage (
  input  logic                       USER_CLK,
  input  logic                       hmc_resetRRRR,
  input  logic                       user_rst_i,
  input  hmc_bringup_pkg::link_vec_t qpll_lock_i,
  input  hmc_bringup_pkg::link_vec_t open_hmc_done_i,
  input  logic                       retry_rst_i,
  output logic                       user_rst_o,
  output hmc_bringup_pkg::link_vec_t trained_o,
  output hmc_bringup_pkg::link_vec_t soft_reset_link_o,
  output logic                       soft_reset_o
);
  import hmc_bringup_pkg::*;

  link_vec_t soft_term;      // Per-link soft reset, not yet synchronized
  logic      soft_term_any;

  logic      [`HMC_SYNC_DEPTH-1:0] user_rst_q;
  logic      [`HMC_SYNC_DEPTH-1:0] soft_any_q;
  link_vec_t                       trained_q   [`HMC_SYNC_DEPTH];
  link_vec_t                       soft_link_q [`HMC_SYNC_DEPTH];

  //----------------------------------------
  // Soft reset terms
  //----------------------------------------
  // Lost lock, user reset or watchdog retry holds a link in reset
  assign soft_term = ~qpll_lock_i | {`HMC_NUM_LINKS{user_rst_i | retry_rst_i}};
  assign soft_term_any = |soft_term;

  //----------------------------------------
  // Synchronizer chains
  //----------------------------------------
  always_ff @(posedge USER_CLK) begin
    if (hmc_resetRRRR) begin
      user_rst_q <= '0;
      soft_any_q <= '0;
      for (int i = 0; i < `HMC_SYNC_DEPTH; i++) begin
        trained_q[i]   <= '0;
        soft_link_q[i] <= '0;
      end
    end else begin
      user_rst_q     <= {user_rst_q[`HMC_SYNC_DEPTH-2:0], user_rst_i};
      soft_any_q     <= {soft_any_q[`HMC_SYNC_DEPTH-2:0], soft_term_any};
      trained_q[0]   <= open_hmc_done_i;
      soft_link_q[0] <= soft_term;
      for (int i = 1; i < `HMC_SYNC_DEPTH; i++) begin
        trained_q[i]   <= trained_q[i-1];
        soft_link_q[i] <= soft_link_q[i-1];
      end
    end
  end

  // Last stage of each chain
  assign user_rst_o        = user_rst_q[`HMC_SYNC_DEPTH-1];
  assign soft_reset_o      = soft_any_q[`HMC_SYNC_DEPTH-1];
  assign trained_o         = trained_q[`HMC_SYNC_DEPTH-1];
  assign soft_reset_link_o = soft_link_q[`HMC_SYNC_DEPTH-1];

endmodule

// File: design/hmc_train_watchdog.sv
// Link-training watchdog for the HMC bring-up supervisor
// Counts cycles until both links report training done and
// issues a fixed-length retry reset when the timeout expires
`timescale 1ns/1ps
`include "hmc_bringup_macros.svh"

module hmc_train_watchdog (
  input  logic                       USER_CLK,
  input  logic                       hmc_resetRRRR,
  input  logic                       user_rst_i,
  input  hmc_bringup_pkg::link_vec_t trained_i,
  output logic                       retry_rst_o
);
  import hmc_bringup_pkg::*;

  train_state_t state_q;
  timeout_cnt_t timeout_cnt_q;
  retry_cnt_t   retry_cnt_q;
  retry_cnt_t   retry_cnt_nxt;
  logic         both_trained;

  assign both_trained = &trained_i;

  // Look ahead so the retry pulse ends after exactly 16 cycles
  assign retry_cnt_nxt = retry_cnt_q + retry_cnt_t'(1);

  //----------------------------------------
  // Watchdog FSM
  //----------------------------------------
  always_ff @(posedge USER_CLK) begin
    if (hmc_resetRRRR || user_rst_i) begin
      state_q       <= WAIT_TRAIN;
      timeout_cnt_q <= '0;
      retry_cnt_q   <= '0;
      retry_rst_o   <= 1'b0;
    end else begin
      case (state_q)
        WAIT_TRAIN: begin
          if (both_trained) begin
            state_q       <= TRAINED;
            timeout_cnt_q <= '0;
          end else if (timeout_cnt_q[`HMC_TIMEOUT_BIT]) begin
            // Training took too long, kick both links
            state_q     <= RETRY;
            retry_cnt_q <= '0;
            retry_rst_o <= 1'b1;
          end else begin
            timeout_cnt_q <= timeout_cnt_q + timeout_cnt_t'(1);
          end
        end

        RETRY: begin
          if (retry_cnt_nxt[`HMC_RETRY_BIT]) begin
            state_q       <= WAIT_TRAIN;   // Start a fresh training window
            retry_rst_o   <= 1'b0;
            retry_cnt_q   <= '0;
            timeout_cnt_q <= '0;
          end else begin
            retry_cnt_q <= retry_cnt_nxt;
          end
        end

        TRAINED: begin
          // A link dropped out, watch again
          if (!both_trained) begin
            state_q <= WAIT_TRAIN;
          end
        end

        default: begin
          state_q     <= WAIT_TRAIN;
          retry_rst_o <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: list.f
+incdir+design
design/hmc_bringup_pkg.sv
design/hmc_sync_stage.sv
design/hmc_train_watchdog.sv
design/hmc_post_monitor.sv
design/hmc_bringup_top.sv
tb/tb_hmc_bringup.sv

// File: tb/tb_hmc_bringup.sv
// Testbench for the HMC bring-up supervisor
// Clock and reset, stimulus for lock, training, retry and POST,
// assertion checks, run watchdog and result reporting
`timescale 1ns/1ps

module tb_hmc_bringup;
  import hmc_bringup_pkg::*;

  // Timing rules of the supervisor
  localparam int CLK_PERIOD     = 8;
  localparam int SYNC_DEPTH     = 4;
  localparam int TIMEOUT_CYCLES = 1024;
  localparam int RETRY_LEN      = 16;

  // Cycle budget per test
  localparam int LEN_RESET     = 16;
  localparam int LEN_LOCK      = 2 * (2 * SYNC_DEPTH + 4);
  localparam int LEN_RETRY     = (TIMEOUT_CYCLES + 64) + (RETRY_LEN + 3 * SYNC_DEPTH)
                                 + (TIMEOUT_CYCLES + 256);
  localparam int LEN_POST_FAIL = 32;
  localparam int LEN_POST_PASS = 40;
  localparam int LEN_USER_RST  = 24;
  localparam int TOTAL_CYCLES  = LEN_RESET + LEN_LOCK + LEN_RETRY + LEN_POST_FAIL
                                 + LEN_POST_PASS + LEN_USER_RST;
  localparam int WDOG_CYCLES   = TOTAL_CYCLES * 6 / 5;   // 20 % margin

  logic      USER_CLK = 1'b0;
  logic      hmc_resetRRRR;
  logic      user_rst_i;
  link_vec_t qpll_lock_i;
  link_vec_t open_hmc_done_i;
  flit_cnt_t rx_flit_cnt_link2_i;
  flit_cnt_t rx_flit_cnt_link3_i;
  flit_cnt_t rx_err_cnt_link2_i;
  flit_cnt_t rx_err_cnt_link3_i;
  link_vec_t soft_reset_link_o;
  logic      soft_reset_o;
  logic      retry_rst_o;
  logic      post_done_o;
  logic      post_ok_o;

  int    seed = 76;
  int    err_cnt;
  int    err_at_start;
  int    pass_cnt;
  int    fail_cnt;
  string test_name;

  hmc_bringup_top u_hmc_bringup_top (
    .USER_CLK            (USER_CLK),
    .hmc_resetRRRR       (hmc_resetRRRR),
    .user_rst_i          (user_rst_i),
    .qpll_lock_i         (qpll_lock_i),
    .open_hmc_done_i     (open_hmc_done_i),
    .rx_flit_cnt_link2_i (rx_flit_cnt_link2_i),
    .rx_flit_cnt_link3_i (rx_flit_cnt_link3_i),
    .rx_err_cnt_link2_i  (rx_err_cnt_link2_i),
    .rx_err_cnt_link3_i  (rx_err_cnt_link3_i),
    .soft_reset_link_o   (soft_reset_link_o),
    .soft_reset_o        (soft_reset_o),
    .retry_rst_o         (retry_rst_o),
    .post_done_o         (post_done_o),
    .post_ok_o           (post_ok_o)
  );

  always #(CLK_PERIOD / 2) USER_CLK = ~USER_CLK;

  // Combined soft reset is the OR of both link resets
  assert property (@(posedge USER_CLK) disable iff (hmc_resetRRRR)
                   soft_reset_o == (|soft_reset_link_o))
  else begin
    $display("ERR %s soft_reset_o expected %0d actual %0d", test_name,
             int'(|soft_reset_link_o), int'(soft_reset_o));
    err_cnt++;
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  task automatic check_val(input string what, input int expected, input int actual);
    assert (actual == expected)
    else begin
      $display("ERR %s %s expected %0d actual %0d", test_name, what, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_cnt;
  endtask

  task automatic finish_test();
    int n;
    n = err_cnt - err_at_start;
    if (n == 0) begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d error(s)", test_name, n);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge USER_CLK);
  endtask

  function automatic flit_cnt_t low_count();
    return flit_cnt_t'($random(seed)) & 16'h00FF;   // Below 256
  endfunction

  function automatic flit_cnt_t high_count();
    return (flit_cnt_t'($random(seed)) & 16'h00FF) | 16'h0100;   // Bit 8 set
  endfunction

  // One link loses PLL lock and only its soft reset follows
  task automatic drop_lock(input int link);
    link_vec_t exp_link;
    exp_link    = link_vec_t'(1 << link);
    qpll_lock_i = ~exp_link;
    wait_cycles(SYNC_DEPTH - 1);
    check_val("soft_reset_link_o early", 0, int'(soft_reset_link_o));
    wait_cycles(1);
    check_val("soft_reset_link_o", int'(exp_link), int'(soft_reset_link_o));
    check_val("soft_reset_o", 1, int'(soft_reset_o));
    qpll_lock_i = '1;
    wait_cycles(SYNC_DEPTH);
    check_val("soft_reset_link_o released", 0, int'(soft_reset_link_o));
  endtask

  //----------------------------------------
  // Tests
  //----------------------------------------
  task automatic reset_values();
    start_test("reset");
    check_val("retry_rst_o", 0, int'(retry_rst_o));
    check_val("post_done_o", 0, int'(post_done_o));
    check_val("post_ok_o", 0, int'(post_ok_o));
    wait_cycles(SYNC_DEPTH + 2);
    check_val("soft_reset_link_o", 0, int'(soft_reset_link_o));
    check_val("retry_rst_o late", 0, int'(retry_rst_o));
    finish_test();
  endtask

  task automatic lock_loss();
    start_test("soft_reset_lock");
    drop_lock(0);
    drop_lock(1);
    finish_test();
  endtask

  task automatic retry_timeout();
    int  wait_cyc;
    int  high_cyc;
    int  soft_cyc;
    bit  seen_retry;
    start_test("retry_reset");
    open_hmc_done_i = '0;
    wait_cyc        = 0;
    while (!retry_rst_o && wait_cyc < TIMEOUT_CYCLES + 64) begin
      wait_cycles(1);
      wait_cyc++;
    end
    assert (retry_rst_o)
    else begin
      $display("retry reset did not rise within %0d cycles", wait_cyc);
      err_cnt++;
    end
    assert (wait_cyc >= TIMEOUT_CYCLES)
    else begin
      $display("retry reset rose after %0d cycles, before the timeout", wait_cyc);
      err_cnt++;
    end

    // Sample 0 is the first cycle with retry high
    high_cyc = 0;
    soft_cyc = 0;
    while (retry_rst_o && high_cyc < RETRY_LEN + 8) begin
      if (high_cyc == SYNC_DEPTH) begin
        check_val("soft_reset_link_o at retry", 3, int'(soft_reset_link_o));
      end
      if (soft_reset_link_o == 2'b11) begin
        soft_cyc++;
      end
      wait_cycles(1);
      high_cyc++;
    end
    check_val("retry_rst_o length", RETRY_LEN, high_cyc);
    while (soft_reset_link_o == 2'b11 && soft_cyc < RETRY_LEN + 8) begin
      soft_cyc++;
      wait_cycles(1);
    end
    assert (soft_cyc >= RETRY_LEN)
    else begin
      $display("link soft resets held only %0d cycles during retry", soft_cyc);
      err_cnt++;
    end

    // Training completes inside the new window
    open_hmc_done_i = '1;
    seen_retry      = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES + 256; i++) begin
      wait_cycles(1);
      if (retry_rst_o) begin
        seen_retry = 1'b1;
      end
    end
    assert (!seen_retry)
    else begin
      $display("retry reset rose although both links finished training");
      err_cnt++;
    end
    finish_test();
  endtask

  task automatic post_with_errors();
    start_test("post_fail");
    rx_err_cnt_link3_i  = flit_cnt_t'($random(seed)) | 16'h0001;
    rx_flit_cnt_link2_i = low_count();
    rx_flit_cnt_link3_i = low_count();
    wait_cycles(SYNC_DEPTH + 2);
    check_val("post_done_o below", 0, int'(post_done_o));
    rx_flit_cnt_link2_i = high_count();
    rx_flit_cnt_link3_i = high_count();
    wait_cycles(1);
    check_val("post_done_o", 1, int'(post_done_o));
    for (int i = 0; i < 2 * SYNC_DEPTH + 2; i++) begin
      wait_cycles(1);
      check_val("post_ok_o", 0, int'(post_ok_o));
    end
    finish_test();
  endtask

  task automatic post_clean();
    start_test("post_pass");
    rx_err_cnt_link2_i = '0;
    rx_err_cnt_link3_i = '0;
    for (int i = 0; i < 8; i++) begin
      rx_flit_cnt_link2_i = low_count();
      rx_flit_cnt_link3_i = low_count();
      wait_cycles(1);
    end
    check_val("post_done_o below", 0, int'(post_done_o));
    check_val("post_ok_o below", 0, int'(post_ok_o));
    rx_flit_cnt_link2_i = high_count();
    rx_flit_cnt_link3_i = high_count();
    wait_cycles(1);
    check_val("post_done_o", 1, int'(post_done_o));
    wait_cycles(SYNC_DEPTH - 1);
    check_val("post_ok_o early", 0, int'(post_ok_o));
    wait_cycles(1);
    check_val("post_ok_o", 1, int'(post_ok_o));
    // Later errors leave the latch set
    rx_err_cnt_link2_i = flit_cnt_t'($random(seed)) | 16'h0001;
    for (int i = 0; i < 10; i++) begin
      wait_cycles(1);
      check_val("post_ok_o held", 1, int'(post_ok_o));
    end
    finish_test();
  endtask

  task automatic user_reset_clear();
    start_test("user_reset");
    user_rst_i = 1'b1;
    wait_cycles(SYNC_DEPTH + 1);
    check_val("post_ok_o", 0, int'(post_ok_o));
    check_val("soft_reset_link_o", 3, int'(soft_reset_link_o));
    user_rst_i = 1'b0;
    wait_cycles(SYNC_DEPTH + 4);
    check_val("soft_reset_link_o released", 0, int'(soft_reset_link_o));
    check_val("post_ok_o after release", 0, int'(post_ok_o));
    finish_test();
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial begin
    err_cnt             = 0;
    err_at_start        = 0;
    pass_cnt            = 0;
    fail_cnt            = 0;
    test_name           = "init";
    hmc_resetRRRR       = 1'b1;
    user_rst_i          = 1'b0;
    qpll_lock_i         = '1;
    open_hmc_done_i     = '1;
    rx_flit_cnt_link2_i = '0;
    rx_flit_cnt_link3_i = '0;
    rx_err_cnt_link2_i  = '0;
    rx_err_cnt_link3_i  = '0;
    wait_cycles(3);
    hmc_resetRRRR = 1'b0;

    reset_values();
    lock_loss();
    retry_timeout();
    post_with_errors();
    post_clean();
    user_reset_clear();

    $display("tests ok %0d, failing %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Run limit from the test budgets
  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("run stopped after %0d cycles, test %s did not finish", WDOG_CYCLES, test_name);
    $display("sim failed");
    $finish;
  end

endmodule
